// File: files.f
+incdir+.
system_pkg.sv
bus_xbar.sv
l2_mem.sv
bootrom.sv
ctrl_registers.sv
system_top.sv
tb_system_top.sv

// File: Makefile
# Verilator build and run of the system testbench
SIM  := obj_dir/Vtb_system_top
SRCS := files.f system_defs.svh system_pkg.sv bus_xbar.sv l2_mem.sv bootrom.sv \
        ctrl_registers.sv system_top.sv tb_vectors.svh tb_system_top.sv

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_system_top -Mdir obj_dir -f files.f

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_vectors.svh
// Rows run one at a time in order; L2 write data is replaced by a random word when applied
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// What the loop does with a row
typedef enum logic [2:0] {
  OP_WR_L2, OP_RD, OP_RD_L2,
  OP_RD_EXT, OP_WAKE, OP_EOC
} op_e;

// Columns: master, operation, request, expected read data
typedef struct packed {
  mst_idx_t mst;
  op_e      op;
  bus_req_t req;
  data_t    exp;  // Unused for writes and for L2 reads
} vec_t;

// Boot loop listing, words 0 to 7
localparam data_t boot_ref [8] = '{
  32'h4000_02b7,
  32'h00c2_a303,
  32'h0010_0393,
  32'h0072_a223,
  32'h1050_0073,
  32'hffdf_f06f,
  32'h0000_0013,
  32'h0000_0013
};

localparam int num_vectors = 25;

// The last L2 row belongs to master 3, so the L2 pointer is back at master 0 afterwards
localparam vec_t vectors [num_vectors] = '{
  '{2'd0, OP_WR_L2,  '{1'b1, 1'b1, `L2_BASE + 32'h00, 32'h0, 4'hf}, 32'h0},
  '{2'd1, OP_WR_L2,  '{1'b1, 1'b1, `L2_BASE + 32'h00, 32'h0, 4'h5}, 32'h0},  // Merge
  '{2'd2, OP_WR_L2,  '{1'b1, 1'b1, `L2_BASE + 32'h14, 32'h0, 4'hc}, 32'h0},
  '{2'd3, OP_WR_L2,  '{1'b1, 1'b1, `L2_BASE + 32'h14, 32'h0, 4'h3}, 32'h0},
  '{2'd2, OP_WR_L2,  '{1'b1, 1'b1, `L2_BASE + 32'h04, 32'h0, 4'hf}, 32'h0},
  '{2'd3, OP_WR_L2,  '{1'b1, 1'b1, `L2_BASE + 32'h08, 32'h0, 4'hf}, 32'h0},
  '{2'd0, OP_RD_L2,  '{1'b1, 1'b0, `L2_BASE + 32'h00, 32'h0, 4'h0}, 32'h0},
  '{2'd1, OP_RD_L2,  '{1'b1, 1'b0, `L2_BASE + 32'h14, 32'h0, 4'h0}, 32'h0},
  '{2'd2, OP_RD_L2,  '{1'b1, 1'b0, `L2_BASE + 32'h04, 32'h0, 4'h0}, 32'h0},
  '{2'd3, OP_RD_L2,  '{1'b1, 1'b0, `L2_BASE + 32'h08, 32'h0, 4'h0}, 32'h0},
  '{2'd0, OP_RD,     '{1'b1, 1'b0, `BOOT_BASE + 32'h00, 32'h0, 4'h0}, boot_ref[0]},
  '{2'd1, OP_RD,     '{1'b1, 1'b0, `BOOT_BASE + 32'h04, 32'h0, 4'h0}, boot_ref[1]},
  '{2'd2, OP_RD,     '{1'b1, 1'b0, `BOOT_BASE + 32'h08, 32'h0, 4'h0}, boot_ref[2]},
  '{2'd3, OP_RD,     '{1'b1, 1'b0, `BOOT_BASE + 32'h0c, 32'h0, 4'h0}, boot_ref[3]},
  '{2'd0, OP_RD,     '{1'b1, 1'b0, `BOOT_BASE + 32'h10, 32'h0, 4'h0}, boot_ref[4]},
  '{2'd1, OP_RD,     '{1'b1, 1'b0, `BOOT_BASE + 32'h14, 32'h0, 4'h0}, boot_ref[5]},
  '{2'd2, OP_RD,     '{1'b1, 1'b0, `BOOT_BASE + 32'h18, 32'h0, 4'h0}, boot_ref[6]},
  '{2'd3, OP_RD,     '{1'b1, 1'b0, `BOOT_BASE + 32'h1c, 32'h0, 4'h0}, boot_ref[7]},
  '{2'd1, OP_RD,     '{1'b1, 1'b0, `BOOT_BASE + 32'h24, 32'h0, 4'h0}, 32'h0},  // Past the table
  '{2'd3, OP_WAKE,   '{1'b1, 1'b1, `CTRL_BASE + 32'h0, 32'h5, 4'hf}, 32'h0},
  '{2'd0, OP_EOC,    '{1'b1, 1'b1, `CTRL_BASE + 32'h4, 32'h1, 4'hf}, 32'h0},
  '{2'd1, OP_RD,     '{1'b1, 1'b0, `CTRL_BASE + 32'h4, 32'h0, 4'h0}, 32'h1},
  '{2'd2, OP_RD,     '{1'b1, 1'b0, `CTRL_BASE + 32'h8, 32'h0, 4'h0}, `NUM_CORES},
  '{2'd3, OP_RD,     '{1'b1, 1'b0, `CTRL_BASE + 32'hc, 32'h0, 4'h0}, `BOOT_ADDR},
  '{2'd0, OP_RD_EXT, '{1'b1, 1'b0, 32'h1234_0000, 32'h0, 4'h0}, 32'h1234_0000 ^ 32'h5a5a_5a5a}
};

`endif

// File: tb_system_top.sv
// Stops at the first mismatch; the external responder here answers each request after one cycle
`timescale 1ns/1ps
`include "system_defs.svh"

module tb_system_top import system_pkg::*; ();

  `include "tb_vectors.svh"

  typedef logic [`NUM_CORES-1:0] core_vec_t;

  localparam int max_cycles = 20 * num_vectors + 200;

  logic                         clk_i;
  logic                         reset_i;
  bus_req_t  [`NUM_MASTERS-1:0] mst_req_i;
  bus_resp_t [`NUM_MASTERS-1:0] mst_resp_o;
  mem_req_t                     ext_req_o;
  logic                         ext_rvalid_i;
  data_t                        ext_rdata_i;
  core_vec_t                    wake_up_o;
  logic                         eoc_valid_o;

  integer seed;
  int     cycles = 0;
  data_t  l2_model [`L2_WORDS]; // Expected L2 contents after byte merging
  logic   eoc_exp;
  logic   ext_pend;             // External request seen this cycle
  addr_t  ext_pend_addr;

  system_top uut (
    .clk_i       (clk_i       ),
    .reset_i     (reset_i     ),
    .mst_req_i   (mst_req_i   ),
    .mst_resp_o  (mst_resp_o  ),
    .ext_req_o   (ext_req_o   ),
    .ext_rvalid_i(ext_rvalid_i),
    .ext_rdata_i (ext_rdata_i ),
    .wake_up_o   (wake_up_o   ),
    .eoc_valid_o (eoc_valid_o )
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // External responder returns the byte address XOR a fixed pattern
  always @(negedge clk_i) begin
    ext_pend      <= ext_req_o.req;
    ext_pend_addr <= {ext_req_o.addr, 2'b00};
  end

  always @(posedge clk_i) begin
    #1;
    ext_rvalid_i = ext_pend;
    ext_rdata_i  = ext_pend ? (ext_pend_addr ^ 32'h5a5a_5a5a) : '0;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_resp(input string name, input bus_resp_t got, input bus_resp_t exp,
                            input bit with_data);
    if (got.gnt !== exp.gnt || got.rvalid !== exp.rvalid ||
        (with_data && got.rdata !== exp.rdata)) begin
      $display("CHECK FAILED at %0t ns: %s (gnt/rvalid/rdata) got %b/%b/%h expected %b/%b/%h",
               $time, name, got.gnt, got.rvalid, got.rdata, exp.gnt, exp.rvalid, exp.rdata);
      abort_run();
    end
  endtask

  task automatic check_ext(input string name, input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input core_vec_t got, input core_vec_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // One table row, granted and answered on the following cycle
  task automatic apply_vector(input vec_t v);
    bus_req_t    req;
    bus_resp_t   exp;
    mem_req_t    ext_exp;
    data_t       rd_exp;
    int unsigned idx;
    string       name;
    req  = v.req;
    idx  = (req.addr >> 2) % `L2_WORDS;
    name = $sformatf("mst_resp_o[%0d]", v.mst);
    if (v.op == OP_WR_L2) begin
      req.wdata = $random(seed);
    end
    @(posedge clk_i);
    #1 mst_req_i[v.mst] = req;
    @(negedge clk_i);
    while (!mst_resp_o[v.mst].gnt) begin
      @(negedge clk_i);
    end
    exp = '{gnt: 1'b1, rvalid: 1'b0, rdata: '0};
    check_resp(name, mst_resp_o[v.mst], exp, 1'b0);
    if (v.op == OP_RD_EXT) begin
      ext_exp = '{req: 1'b1, we: req.we, addr: req.addr[31:2], wdata: req.wdata, strb: req.strb};
      check_ext("ext_req_o", ext_req_o, ext_exp);
    end
    if (v.op == OP_WR_L2) begin
      for (int b = 0; b < 4; b++) begin
        if (req.strb[b]) begin
          l2_model[idx][8*b +: 8] = req.wdata[8*b +: 8];
        end
      end
    end
    rd_exp = (v.op == OP_RD_L2) ? l2_model[idx] : v.exp;
    @(posedge clk_i);
    #1 mst_req_i[v.mst] = '0;
    @(negedge clk_i);
    if (v.op == OP_EOC) begin
      eoc_exp = req.wdata[0];
    end
    exp = '{gnt: 1'b0, rvalid: 1'b1, rdata: rd_exp};
    check_resp(name, mst_resp_o[v.mst], exp, v.op inside {OP_RD, OP_RD_L2, OP_RD_EXT});
    check_bit("wake_up_o", wake_up_o, (v.op == OP_WAKE) ? req.wdata[`NUM_CORES-1:0] : '0);
    check_bit("eoc_valid_o", core_vec_t'(eoc_valid_o), core_vec_t'(eoc_exp));
    @(negedge clk_i);
    check_bit("wake_up_o", wake_up_o, '0);  // Pulse is gone again
  endtask

  // All masters hold L2 reads and master 0 asks again after its first grant,
  // so grants rotate 0, 1, 2, 3 before master 0 is served a second time
  task automatic contend_for_l2();
    int        words [`NUM_MASTERS];
    int        order [`NUM_MASTERS+1]; // Expected winner per cycle
    int        gnt_m;
    int        rv_m;
    bus_resp_t exp;
    words = '{0, 1, 2, 5};
    order = '{0, 1, 2, 3, 0};
    @(posedge clk_i);
    #1;
    for (int m = 0; m < `NUM_MASTERS; m++) begin
      mst_req_i[m] = '{1'b1, 1'b0, `L2_BASE + 32'(4 * words[m]), 32'h0, 4'h0};
    end
    for (int c = 0; c <= `NUM_MASTERS + 1; c++) begin
      gnt_m = -1;
      rv_m  = -1;
      if (c <= `NUM_MASTERS) begin
        gnt_m = order[c];
      end
      if (c > 0) begin
        rv_m = order[c-1];
      end
      @(negedge clk_i);
      for (int m = 0; m < `NUM_MASTERS; m++) begin
        exp = '{m == gnt_m, m == rv_m, l2_model[words[m]]};
        check_resp($sformatf("mst_resp_o[%0d]", m), mst_resp_o[m], exp, m == rv_m);
      end
      @(posedge clk_i);
      #1;
      // Master 0 keeps its request after the first grant
      if (c > 0 && c <= `NUM_MASTERS) begin
        mst_req_i[gnt_m] = '0;
      end
    end
  endtask

  // One master per target, all granted together
  task automatic hit_all_targets();
    bus_req_t  reqs [`NUM_MASTERS];
    data_t     exps [`NUM_MASTERS];
    bus_resp_t exp;
    reqs[0] = '{1'b1, 1'b0, `CTRL_BASE + 32'h8, 32'h0, 4'h0};
    reqs[1] = '{1'b1, 1'b0, `L2_BASE, 32'h0, 4'h0};
    reqs[2] = '{1'b1, 1'b0, `BOOT_BASE + 32'hc, 32'h0, 4'h0};
    reqs[3] = '{1'b1, 1'b0, 32'h0000_1000, 32'h0, 4'h0};
    exps[0] = `NUM_CORES;
    exps[1] = l2_model[0];
    exps[2] = boot_ref[3];
    exps[3] = 32'h0000_1000 ^ 32'h5a5a_5a5a;
    @(posedge clk_i);
    #1;
    for (int m = 0; m < `NUM_MASTERS; m++) begin
      mst_req_i[m] = reqs[m];
    end
    @(negedge clk_i);
    for (int m = 0; m < `NUM_MASTERS; m++) begin
      exp = '{1'b1, 1'b0, '0};
      check_resp($sformatf("mst_resp_o[%0d]", m), mst_resp_o[m], exp, 1'b0);
    end
    @(posedge clk_i);
    #1 mst_req_i = '0;
    @(negedge clk_i);
    for (int m = 0; m < `NUM_MASTERS; m++) begin
      exp = '{1'b0, 1'b1, exps[m]};
      check_resp($sformatf("mst_resp_o[%0d]", m), mst_resp_o[m], exp, 1'b1);
    end
  endtask

  initial begin
    seed         = 32'hdd33_863a;
    reset_i      = 1'b1;
    mst_req_i    = '0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    ext_pend     = 1'b0;
    eoc_exp      = 1'b0;
    foreach (l2_model[i]) begin
      l2_model[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    #1 reset_i = 1'b0;
    @(negedge clk_i);
    for (int m = 0; m < `NUM_MASTERS; m++) begin
      check_resp($sformatf("mst_resp_o[%0d]", m), mst_resp_o[m], '0, 1'b0);
    end
    check_bit("ext_req_o.req", core_vec_t'(ext_req_o.req), '0);
    check_bit("wake_up_o", wake_up_o, '0);
    check_bit("eoc_valid_o", core_vec_t'(eoc_valid_o), '0);
    foreach (vectors[i]) begin
      apply_vector(vectors[i]);
    end
    contend_for_l2();
    hit_all_targets();
    $display("TEST PASSED");
    $finish;
  end

endmodule : tb_system_top

// File: system_top.sv
// The external responder must return rvalid exactly one cycle after each ext_req_o.req
`timescale 1ns/1ps
`include "system_defs.svh"

module system_top import system_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  bus_req_t  [`NUM_MASTERS-1:0] mst_req_i,
  output bus_resp_t [`NUM_MASTERS-1:0] mst_resp_o,
  output mem_req_t                     ext_req_o,
  input  logic                         ext_rvalid_i,
  input  data_t                        ext_rdata_i,
  output logic      [`NUM_CORES-1:0]   wake_up_o,
  output logic                         eoc_valid_o
);

  mem_req_t [num_targets-1:0] tgt_req;
  logic     [num_targets-1:0] tgt_rvalid;
  data_t    [num_targets-1:0] tgt_rdata;

  bus_xbar i_bus_xbar (
    .clk_i       (clk_i     ),
    .reset_i     (reset_i   ),
    .mst_req_i   (mst_req_i ),
    .mst_resp_o  (mst_resp_o),
    .tgt_req_o   (tgt_req   ),
    .tgt_rvalid_i(tgt_rvalid),
    .tgt_rdata_i (tgt_rdata )
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i               ),
    .reset_i    (reset_i             ),
    .req_i      (tgt_req[TGT_CTRL]   ),
    .rvalid_o   (tgt_rvalid[TGT_CTRL]),
    .rdata_o    (tgt_rdata[TGT_CTRL] ),
    .wake_up_o  (wake_up_o           ),
    .eoc_valid_o(eoc_valid_o         )
  );

  l2_mem i_l2_mem (
    .clk_i   (clk_i             ),
    .reset_i (reset_i           ),
    .req_i   (tgt_req[TGT_L2]   ),
    .rvalid_o(tgt_rvalid[TGT_L2]),
    .rdata_o (tgt_rdata[TGT_L2] )
  );

  bootrom i_bootrom (
    .clk_i   (clk_i               ),
    .reset_i (reset_i             ),
    .req_i   (tgt_req[TGT_BOOT]   ),
    .rvalid_o(tgt_rvalid[TGT_BOOT]),
    .rdata_o (tgt_rdata[TGT_BOOT] )
  );

  // Default route leaves the system unchanged
  assign ext_req_o           = tgt_req[TGT_EXT];
  assign tgt_rvalid[TGT_EXT] = ext_rvalid_i;
  assign tgt_rdata[TGT_EXT]  = ext_rdata_i;

endmodule : system_top

// File: ctrl_registers.sv
// Only word offsets 0 to 3 are mapped; wake-up ignores strobes and reads back as zero
`timescale 1ns/1ps
`include "system_defs.svh"

module ctrl_registers import system_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mem_req_t              req_i,
  output logic                  rvalid_o,
  output data_t                 rdata_o,
  output logic [`NUM_CORES-1:0] wake_up_o,
  output logic                  eoc_valid_o
);

  localparam int unsigned off_w = $clog2(`CTRL_END - `CTRL_BASE + 1) - 2;

  // Word offsets
  localparam logic [off_w-1:0] reg_wake      = 'd0;
  localparam logic [off_w-1:0] reg_eoc       = 'd1;
  localparam logic [off_w-1:0] reg_num_cores = 'd2;
  localparam logic [off_w-1:0] reg_boot_addr = 'd3;

  logic [off_w-1:0] offset;
  logic             wr_en;
  logic             rd_en;
  data_t            eoc_q;
  data_t            rd_word;

  assign offset = req_i.addr[off_w-1:0];
  assign wr_en  = req_i.req && req_i.we;
  assign rd_en  = req_i.req && !req_i.we;

  // Bit 0 of the stored value flags end of computation
  assign eoc_valid_o = eoc_q[0];

  always_comb begin
    case (offset)
      reg_eoc:       rd_word = eoc_q;
      reg_num_cores: rd_word = data_t'(`NUM_CORES);
      reg_boot_addr: rd_word = `BOOT_ADDR;
      default:       rd_word = '0; // Wake-up and unmapped offsets
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o  <= 1'b0;
      wake_up_o <= '0;
      eoc_q     <= '0;
    end else begin
      rvalid_o  <= req_i.req;
      wake_up_o <= '0; // Pulse lasts a single cycle
      if (wr_en && offset == reg_wake) begin
        wake_up_o <= req_i.wdata[`NUM_CORES-1:0];
      end
      if (wr_en && offset == reg_eoc) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.strb[b]) begin
            eoc_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Read data registered, held otherwise
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_o <= rd_word;
    end
  end

endmodule : ctrl_registers

// File: bootrom.sv
// Eight-word fixed boot loop; writes are acknowledged and dropped, other words read zero
`timescale 1ns/1ps
`include "system_defs.svh"

module bootrom import system_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_req_t req_i,
  output logic     rvalid_o,
  output data_t    rdata_o
);

  localparam int unsigned off_w = $clog2(`BOOT_END - `BOOT_BASE + 1) - 2;

  logic [off_w-1:0] offset; // Word offset inside the window
  data_t            rom_word;

  assign offset = req_i.addr[off_w-1:0];

  always_comb begin
    case (offset)
      'd0:     rom_word = 32'h4000_02b7; // lui  t0, 0x40000
      'd1:     rom_word = 32'h00c2_a303; // lw   t1, 12(t0)
      'd2:     rom_word = 32'h0010_0393; // addi t2, zero, 1
      'd3:     rom_word = 32'h0072_a223; // sw   t2, 4(t0)
      'd4:     rom_word = 32'h1050_0073; // wfi
      'd5:     rom_word = 32'hffdf_f06f; // j    back to wfi
      'd6:     rom_word = 32'h0000_0013; // nop
      'd7:     rom_word = 32'h0000_0013;
      default: rom_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_o <= rom_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i.req;
    end
  end

endmodule : bootrom

// File: l2_mem.sv
// Word index wraps at the L2 depth, so any word address in the window hits some word
`timescale 1ns/1ps
`include "system_defs.svh"

module l2_mem import system_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_req_t req_i,
  output logic     rvalid_o,
  output data_t    rdata_o
);

  localparam int unsigned idx_w = $clog2(`L2_WORDS);

  data_t            mem_q [`L2_WORDS];
  logic [idx_w-1:0] idx;

  assign idx = req_i.addr[idx_w-1:0]; // Modulo depth

  // Byte lanes written under strobe; reads leave rdata for the next cycle
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.strb[b]) begin
            mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

  // Every request, read or write, is answered once
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i.req;
    end
  end

endmodule : l2_mem

// File: bus_xbar.sv
// Masters must hold an ungranted request; every target must answer exactly one cycle after it
`timescale 1ns/1ps
`include "system_defs.svh"

module bus_xbar import system_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  bus_req_t  [`NUM_MASTERS-1:0] mst_req_i,
  output bus_resp_t [`NUM_MASTERS-1:0] mst_resp_o,
  output mem_req_t  [num_targets-1:0]  tgt_req_o,
  input  logic      [num_targets-1:0]  tgt_rvalid_i,
  input  data_t     [num_targets-1:0]  tgt_rdata_i
);

  target_e                  mst_tgt   [`NUM_MASTERS]; // Decoded target per master
  logic [num_targets-1:0]   tgt_gnt;                  // Target has a winner this cycle
  mst_idx_t                 tgt_win   [num_targets];
  mst_idx_t                 rr_ptr_q  [num_targets];  // First master to look at
  logic [num_targets-1:0]   rsp_valid_q;
  mst_idx_t                 rsp_mst_q [num_targets];  // Owner of the pending response

  // Address map, anything unmapped leaves through the external port
  function automatic target_e decode(input addr_t addr);
    target_e tgt;
    tgt = TGT_EXT;
    if (addr >= `CTRL_BASE && addr <= `CTRL_END) begin
      tgt = TGT_CTRL;
    end else if (addr >= `L2_BASE && addr <= `L2_END) begin
      tgt = TGT_L2;
    end else if (addr >= `BOOT_BASE && addr <= `BOOT_END) begin
      tgt = TGT_BOOT;
    end
    return tgt;
  endfunction

  always_comb begin
    for (int m = 0; m < `NUM_MASTERS; m++) begin
      mst_tgt[m] = decode(mst_req_i[m].addr);
    end
  end

  // Round-robin search per target, starting at its pointer
  always_comb begin
    int idx;
    for (int t = 0; t < num_targets; t++) begin
      tgt_gnt[t] = 1'b0;
      tgt_win[t] = '0;
      for (int k = 0; k < `NUM_MASTERS; k++) begin
        idx = (int'(rr_ptr_q[t]) + k) % `NUM_MASTERS;
        if (!tgt_gnt[t] && mst_req_i[idx].req && mst_tgt[idx] == target_e'(t)) begin
          tgt_gnt[t] = 1'b1;
          tgt_win[t] = mst_idx_t'(idx);
        end
      end
    end
  end

  // Forward the winner's fields to each target
  always_comb begin
    for (int t = 0; t < num_targets; t++) begin
      tgt_req_o[t].req   = tgt_gnt[t];
      tgt_req_o[t].we    = mst_req_i[tgt_win[t]].we;
      tgt_req_o[t].addr  = mst_req_i[tgt_win[t]].addr[31:2]; // Word address
      tgt_req_o[t].wdata = mst_req_i[tgt_win[t]].wdata;
      tgt_req_o[t].strb  = mst_req_i[tgt_win[t]].strb;
    end
  end

  // Grant now, response steered by what was recorded last cycle
  always_comb begin
    for (int m = 0; m < `NUM_MASTERS; m++) begin
      mst_resp_o[m] = '0;
      for (int t = 0; t < num_targets; t++) begin
        if (tgt_gnt[t] && tgt_win[t] == mst_idx_t'(m)) begin
          mst_resp_o[m].gnt = 1'b1;
        end
        if (rsp_valid_q[t] && tgt_rvalid_i[t] && rsp_mst_q[t] == mst_idx_t'(m)) begin
          mst_resp_o[m].rvalid = 1'b1;
          mst_resp_o[m].rdata  = tgt_rdata_i[t];
        end
      end
    end
  end

  // One master holds at most one grant, so two targets never answer the same master

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= '0;
      for (int t = 0; t < num_targets; t++) begin
        rr_ptr_q[t]  <= '0;
        rsp_mst_q[t] <= '0;
      end
    end else begin
      for (int t = 0; t < num_targets; t++) begin
        rsp_valid_q[t] <= tgt_gnt[t];
        if (tgt_gnt[t]) begin
          rsp_mst_q[t] <= tgt_win[t];
          // Next search begins after the winner
          rr_ptr_q[t]  <= mst_idx_t'((int'(tgt_win[t]) + 1) % `NUM_MASTERS);
        end
      end
    end
  end

endmodule : bus_xbar

// File: system_pkg.sv
// Bus types for 32-bit single-word transfers; there are no bursts and no atomics
`include "system_defs.svh"

package system_pkg;

  // Control registers, L2, boot ROM and the external port
  localparam int unsigned num_targets = 4;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [29:0] word_addr_t;                      // Byte address minus its offset bits
  typedef logic [$clog2(`NUM_MASTERS)-1:0] mst_idx_t;

  // Request as issued by a master
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;    // Same cycle as req
    logic  rvalid; // One cycle after gnt
    data_t rdata;
  } bus_resp_t;

  // Request as seen by a target, word addressed
  typedef struct packed {
    logic       req;
    logic       we;
    word_addr_t addr;
    data_t      wdata;
    strb_t      strb;
  } mem_req_t;

  typedef enum logic [1:0] {
    TGT_CTRL = 2'd0,
    TGT_L2   = 2'd1,
    TGT_BOOT = 2'd2,
    TGT_EXT  = 2'd3
  } target_e;

endpackage : system_pkg

// File: system_defs.svh
// Address windows are inclusive and must not overlap; L2 depth must be a power of two
`ifndef SYSTEM_DEFS_SVH
`define SYSTEM_DEFS_SVH

// Requesting ports, cores plus the host
`define NUM_MASTERS 4
`define NUM_CORES   3

// Control register window
`define CTRL_BASE 32'h4000_0000
`define CTRL_END  32'h4000_FFFF

// L2 scratch memory, window end follows from the depth
`define L2_BASE  32'h8000_0000
`define L2_WORDS 64
`define L2_END   (`L2_BASE + (`L2_WORDS * 32'd4) - 32'd1)

// Boot ROM window
`define BOOT_BASE 32'hA000_0000
`define BOOT_END  32'hA000_FFFF

// Reset fetch address reported to the cores
`define BOOT_ADDR 32'hA000_0000

`endif
